// File: source/exu_pkg.sv
package exu_pkg;

   localparam int xlen       = 32;
   localparam int reg_addr_w = 5;
   localparam int num_regs   = 32;
   localparam int imm_w      = 18;

   typedef enum logic [3:0] {
      op_add,
      op_sub,
      op_and,
      op_or,
      op_xor,
      op_slt,
      op_addi,
      op_andi,
      op_ori,
      op_load,
      op_store
   } op_t;

   // register-register view
   typedef struct packed {
      op_t                   opcode;
      logic [reg_addr_w-1:0] rd;
      logic [reg_addr_w-1:0] rs1;
      logic [reg_addr_w-1:0] rs2;
      logic [12:0]           pad;
   } inst_r_t;

   // register-immediate view, also loads and stores
   typedef struct packed {
      op_t                   opcode;
      logic [reg_addr_w-1:0] rd;
      logic [reg_addr_w-1:0] rs1;
      logic signed [imm_w-1:0] imm;
   } inst_i_t;

   typedef union packed {
      inst_r_t r;
      inst_i_t i;
   } inst_t;

   typedef struct packed {
      logic  valid;
      inst_t word;
   } issue_t;

   typedef struct packed {
      op_t                   alu_op;
      logic                  use_imm;
      logic                  is_load;
      logic                  is_store;
      logic                  wen;
      logic [reg_addr_w-1:0] rd;
   } ex_ctrl_t;

   typedef struct packed {
      logic                  valid;
      logic [reg_addr_w-1:0] rd;
      logic [xlen-1:0]       data;
   } wb_t;

   typedef struct packed {
      logic            we;
      logic [xlen-1:0] addr;
      logic [xlen-1:0] wdata;
   } mem_req_t;

   // second source register; a store names its data register in the rd field
   function automatic logic [reg_addr_w-1:0] src2_addr(input inst_t word);
      return (word.r.opcode == op_store) ? word.i.rd : word.r.rs2;
   endfunction

endpackage

// File: source/exu_issue_ctrl.sv
module exu_issue_ctrl import exu_pkg::*; (
   input  logic     clk,
   input  logic     rst_n,
   input  issue_t   issue,
   output logic     stall,
   output ex_ctrl_t ex_ctrl,
   output logic     ex_valid,
   output logic     mem_req,
   input  logic     mem_ack,
   output logic     lsu_done_m
);

   typedef enum logic [1:0] {
      s_idle,
      s_req,
      s_ack_low,
      s_done
   } lsu_state_t;

   lsu_state_t state;
   lsu_state_t state_next;
   op_t        op_d;
   logic       lsu_op_d;
   logic       alu_dispatch_d;
   logic       lsu_dispatch_d;
   ex_ctrl_t   ctrl_d;

   ////////////////////////////////////////////////////////////
   // dispatch
   ////////////////////////////////////////////////////////////

   // opcode sits in the same place in both views
   assign op_d     = issue.word.r.opcode;
   assign lsu_op_d = (op_d == op_load) || (op_d == op_store);

   // new work only from idle; in s_done the finished memory op is retired
   assign alu_dispatch_d = issue.valid && (state == s_idle) && !lsu_op_d;
   assign lsu_dispatch_d = issue.valid && (state == s_idle) && lsu_op_d;

   always_comb begin
      ctrl_d          = '0;
      ctrl_d.alu_op   = op_d;
      ctrl_d.use_imm  = op_d inside {op_addi, op_andi, op_ori, op_load, op_store};
      ctrl_d.is_load  = (op_d == op_load);
      ctrl_d.is_store = (op_d == op_store);
      ctrl_d.rd       = issue.word.i.rd;
      // r0 writes are dropped here so they never reach writeback
      ctrl_d.wen      = !ctrl_d.is_store && (ctrl_d.rd != '0);
   end

   // e stage control follows the issue word, the held memory op reloads itself
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ex_ctrl  <= '0;
         ex_valid <= 1'b0;
      end else begin
         ex_valid <= alu_dispatch_d || lsu_dispatch_d;
         if (issue.valid) begin
            ex_ctrl <= ctrl_d;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // four-phase memory handshake
   ////////////////////////////////////////////////////////////

   always_comb begin
      state_next = state;
      case (state)
         s_idle:    if (lsu_dispatch_d) state_next = s_req;
         s_req:     if (mem_ack) state_next = s_ack_low;
         s_ack_low: if (!mem_ack) state_next = s_done;
         s_done:    state_next = s_idle;
         default:   state_next = s_idle;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= s_idle;
      end else begin
         state <= state_next;
      end
   end

   // req drops as soon as ack is seen
   assign mem_req    = (state == s_req) && !mem_ack;
   assign lsu_done_m = (state == s_req) && mem_ack && ex_ctrl.is_load;

   // high from the first cycle of a memory op until ack has gone low
   assign stall = lsu_dispatch_d || (state == s_req) || (state == s_ack_low);

endmodule

// File: source/exu_regfile.sv
module exu_regfile import exu_pkg::*; (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic [reg_addr_w-1:0] rs1,
   input  logic [reg_addr_w-1:0] rs2,
   output logic [xlen-1:0]       rs1_data,
   output logic [xlen-1:0]       rs2_data,
   input  wb_t                   wr
);

   logic [xlen-1:0] regs [num_regs];

   // write port from the w stage
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         regs <= '{default: '0};
      end else if (wr.valid && (wr.rd != '0)) begin
         regs[wr.rd] <= wr.data;
      end
   end

   // r0 is hardwired
   assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
   assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: source/exu_bypass.sv
module exu_bypass import exu_pkg::*; (
   input  logic            clk,
   input  logic            rst_n,
   input  issue_t          issue,
   input  logic [xlen-1:0] rs1_data,
   input  logic [xlen-1:0] rs2_data,
   input  ex_ctrl_t        ex_ctrl,
   input  wb_t             m_fwd,
   input  wb_t             w_fwd,
   output logic [xlen-1:0] op_a,
   output logic [xlen-1:0] op_b,
   output logic [xlen-1:0] store_data
);

   logic [reg_addr_w-1:0] rs1_d;
   logic [reg_addr_w-1:0] rs2_d;
   logic [reg_addr_w-1:0] rs1_e;
   logic [reg_addr_w-1:0] rs2_e;
   logic [xlen-1:0]       rs1_val_e;
   logic [xlen-1:0]       rs2_val_e;
   logic [xlen-1:0]       imm_e;
   logic [xlen-1:0]       rs2_fwd;

   // take rec's data when it writes the register being read
   function automatic logic [xlen-1:0] fwd(input logic [reg_addr_w-1:0] rs,
                                           input logic [xlen-1:0] base,
                                           input wb_t rec);
      return (rec.valid && (rec.rd == rs) && (rs != '0)) ? rec.data : base;
   endfunction

   assign rs1_d = issue.word.r.rs1;
   assign rs2_d = src2_addr(issue.word);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rs1_e <= '0;
         rs2_e <= '0;
      end else if (issue.valid) begin
         rs1_e <= rs1_d;
         rs2_e <= rs2_d;
      end
   end

   // w writes the file on this edge, so catch it on the way in
   always_ff @(posedge clk) begin
      if (issue.valid) begin
         rs1_val_e <= fwd(rs1_d, rs1_data, w_fwd);
         rs2_val_e <= fwd(rs2_d, rs2_data, w_fwd);
         imm_e     <= {{(xlen-imm_w){issue.word.i.imm[imm_w-1]}}, issue.word.i.imm};
      end
   end

   ////////////////////////////////////////////////////////////
   // operand select in e with m ahead of w
   ////////////////////////////////////////////////////////////

   assign op_a    = fwd(rs1_e, fwd(rs1_e, rs1_val_e, w_fwd), m_fwd);
   assign rs2_fwd = fwd(rs2_e, fwd(rs2_e, rs2_val_e, w_fwd), m_fwd);

   assign op_b       = ex_ctrl.use_imm ? imm_e : rs2_fwd;
   assign store_data = rs2_fwd;

endmodule

// File: source/exu_alu.sv
module exu_alu import exu_pkg::*; (
   input  op_t             op,
   input  logic [xlen-1:0] a,
   input  logic [xlen-1:0] b,
   output logic [xlen-1:0] result
);

   always_comb begin
      result = '0;
      case (op)
         // loads and stores form base plus offset
         op_add, op_addi, op_load, op_store: begin
            result = a + b;
         end
         op_sub: begin
            result = a - b;
         end
         op_and, op_andi: begin
            result = a & b;
         end
         op_or, op_ori: begin
            result = a | b;
         end
         op_xor: begin
            result = a ^ b;
         end
         op_slt: begin
            result[0] = $signed(a) < $signed(b);
         end
         default: begin
            result = '0;
         end
      endcase
   end

endmodule

// File: source/exu_writeback.sv
module exu_writeback import exu_pkg::*; (
   input  logic            clk,
   input  logic            rst_n,
   input  ex_ctrl_t        ex_ctrl,
   input  logic            ex_valid,
   input  logic [xlen-1:0] alu_result,
   input  logic            lsu_done_m,
   input  logic [xlen-1:0] mem_rdata,
   output wb_t             m_fwd,
   output wb_t             w_fwd
);

   logic alu_wr_e;
   wb_t  m_next;

   ////////////////////////////////////////////////////////////
   // e to m, source select
   ////////////////////////////////////////////////////////////

   assign alu_wr_e = ex_valid && ex_ctrl.wen && !ex_ctrl.is_load && !ex_ctrl.is_store;

   // load rd is the one held in e while the transfer runs
   always_comb begin
      m_next.valid = alu_wr_e || (lsu_done_m && ex_ctrl.wen);
      m_next.rd    = ex_ctrl.rd;
      m_next.data  = lsu_done_m ? mem_rdata : alu_result;
   end

   ////////////////////////////////////////////////////////////
   // m and w registers
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         m_fwd <= '0;
         w_fwd <= '0;
      end else begin
         m_fwd <= m_next;
         // w feeds both the register file and the wb port
         w_fwd <= m_fwd;
      end
   end

endmodule

// File: source/exu_top.sv
module exu_top import exu_pkg::*; (
   input  logic            clk,
   input  logic            rst_n,
   input  issue_t          issue,
   output logic            stall,
   output logic            mem_req,
   output mem_req_t        mem,
   input  logic            mem_ack,
   input  logic [xlen-1:0] mem_rdata,
   output wb_t             wb
);

   ex_ctrl_t              ex_ctrl;
   logic                  ex_valid;
   logic                  lsu_done_m;
   logic [reg_addr_w-1:0] rf_rs1;
   logic [reg_addr_w-1:0] rf_rs2;
   logic [xlen-1:0]       rs1_data;
   logic [xlen-1:0]       rs2_data;
   logic [xlen-1:0]       op_a;
   logic [xlen-1:0]       op_b;
   logic [xlen-1:0]       store_data;
   logic [xlen-1:0]       alu_result;
   wb_t                   m_fwd;
   wb_t                   w_fwd;

   // d stage register reads
   assign rf_rs1 = issue.word.r.rs1;
   assign rf_rs2 = src2_addr(issue.word);

   exu_issue_ctrl u_ctrl (
      .clk        (clk),
      .rst_n      (rst_n),
      .issue      (issue),
      .stall      (stall),
      .ex_ctrl    (ex_ctrl),
      .ex_valid   (ex_valid),
      .mem_req    (mem_req),
      .mem_ack    (mem_ack),
      .lsu_done_m (lsu_done_m)
   );

   exu_regfile u_regfile (
      .clk      (clk),
      .rst_n    (rst_n),
      .rs1      (rf_rs1),
      .rs2      (rf_rs2),
      .rs1_data (rs1_data),
      .rs2_data (rs2_data),
      .wr       (w_fwd)
   );

   exu_bypass u_bypass (
      .clk        (clk),
      .rst_n      (rst_n),
      .issue      (issue),
      .rs1_data   (rs1_data),
      .rs2_data   (rs2_data),
      .ex_ctrl    (ex_ctrl),
      .m_fwd      (m_fwd),
      .w_fwd      (w_fwd),
      .op_a       (op_a),
      .op_b       (op_b),
      .store_data (store_data)
   );

   exu_alu u_alu (
      .op     (ex_ctrl.alu_op),
      .a      (op_a),
      .b      (op_b),
      .result (alu_result)
   );

   exu_writeback u_writeback (
      .clk        (clk),
      .rst_n      (rst_n),
      .ex_ctrl    (ex_ctrl),
      .ex_valid   (ex_valid),
      .alu_result (alu_result),
      .lsu_done_m (lsu_done_m),
      .mem_rdata  (mem_rdata),
      .m_fwd      (m_fwd),
      .w_fwd      (w_fwd)
   );

   // address is the ALU sum, held stable while the op sits in e
   assign mem.we    = ex_ctrl.is_store;
   assign mem.addr  = alu_result;
   assign mem.wdata = store_data;

   assign wb = w_fwd;

endmodule

// File: tests/tb_mem_model.sv
module tb_mem_model import exu_pkg::*; (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            mem_req,
   input  mem_req_t        mem,
   output logic            mem_ack,
   output logic [xlen-1:0] mem_rdata
);

   logic [xlen-1:0] words [64];
   mem_req_t        held;
   int unsigned     delay;

   // contents depend on every word address bit
   initial begin
      for (int i = 0; i < 64; i++) begin
         words[i] = 32'ha5a5_0000 ^ (i * 32'h0001_0203);
      end
   end

   // one transfer at a time with a random wait before each ack edge
   initial begin
      void'($urandom(62390));
      mem_ack   = 1'b0;
      mem_rdata = '0;
      forever begin
         @(negedge clk);
         if (rst_n && mem_req) begin
            held  = mem;
            delay = $urandom_range(3, 0);
            repeat (delay) @(negedge clk);
            @(posedge clk);
            #2;
            if (held.we) begin
               words[held.addr[7:2]] = held.wdata;
            end else begin
               mem_rdata = words[held.addr[7:2]];
            end
            mem_ack = 1'b1;
            // ack stays up for at least one edge
            delay = $urandom_range(3, 1);
            repeat (delay) @(posedge clk);
            #2;
            mem_ack = 1'b0;
         end
      end
   end

endmodule

// File: tests/tb_exu_top.sv
module tb_exu_top import exu_pkg::*; ();

   logic            clk;
   logic            rst_n;
   issue_t          issue;
   logic            stall;
   logic            mem_req;
   mem_req_t        mem;
   logic            mem_ack;
   logic [xlen-1:0] mem_rdata;
   wb_t             wb;

   // stimulus table filled by the predictor
   logic [31:0]     row_word [$];
   logic [4:0]      row_rd   [$];
   logic [xlen-1:0] row_data [$];
   bit              row_wb   [$];
   bit              row_alu  [$];
   mem_req_t        exp_mem  [$];
   int              accept_cycle [64];
   logic [xlen-1:0] pred_regs [32];
   logic [xlen-1:0] pred_mem  [64];
   int              cycle       = 0;
   int              wb_count    = 0;
   int              wb_expected = 0;
   logic            prev_req    = 1'b0;
   logic            prev_ack    = 1'b0;

   initial clk = 1'b0;
   always #10 clk = ~clk;

   exu_top u_dut (
      .clk       (clk),
      .rst_n     (rst_n),
      .issue     (issue),
      .stall     (stall),
      .mem_req   (mem_req),
      .mem       (mem),
      .mem_ack   (mem_ack),
      .mem_rdata (mem_rdata),
      .wb        (wb)
   );

   tb_mem_model u_mem (
      .clk       (clk),
      .rst_n     (rst_n),
      .mem_req   (mem_req),
      .mem       (mem),
      .mem_ack   (mem_ack),
      .mem_rdata (mem_rdata)
   );

   task automatic check_val(input string name, input logic [31:0] got,
                            input logic [31:0] want);
      if (got !== want) begin
         $display("Error at %0t: %s is %h, expected %h", $time, name, got, want);
         $display("** FAIL **");
         $fatal(1);
      end
   endtask

   task automatic report_timeout(input string what);
      $display("Timeout at %0t while waiting for %s", $time, what);
      $display("** FAIL **");
      $fatal(1);
   endtask

   // compare a new request with the next load or store of the table
   task automatic check_mem_req();
      mem_req_t want;
      if (exp_mem.size() == 0) begin
         $display("Memory request at %0t with no load or store pending", $time);
         $display("** FAIL **");
         $fatal(1);
      end
      want = exp_mem.pop_front();
      check_val("mem.we", mem.we, want.we);
      check_val("mem.addr", mem.addr, want.addr);
      if (want.we) begin
         check_val("mem.wdata", mem.wdata, want.wdata);
      end
   endtask

   always @(posedge clk) begin
      cycle <= cycle + 1;
   end

   ////////////////////////////////////////////////////////////
   // four-phase order and stall sampled mid cycle
   ////////////////////////////////////////////////////////////

   always @(negedge clk) begin
      if (rst_n) begin
         if (wb.valid) begin
            wb_count++;
         end
         if (mem_ack && !prev_ack) begin
            check_val("mem_req before ack rise", prev_req, 1);
         end
         if (mem_req && !prev_req) begin
            check_val("mem_ack at req rise", mem_ack, 0);
            check_mem_req();
         end
         if (mem_ack) begin
            check_val("mem_req while ack high", mem_req, 0);
         end
         if (mem_req || mem_ack) begin
            check_val("stall during transfer", stall, 1);
         end
      end
      prev_req <= mem_req;
      prev_ack <= mem_ack;
   end

   ////////////////////////////////////////////////////////////
   // predictor and table
   ////////////////////////////////////////////////////////////

   // src2 is rs2 for register forms, the immediate otherwise; a store's rd is its data
   task automatic add_inst(input op_t op, input int rd, input int rs1, input int src2);
      logic [31:0]     word;
      logic [xlen-1:0] a;
      logic [xlen-1:0] b;
      logic [xlen-1:0] addr;
      logic [xlen-1:0] res;
      bit              reg_form;
      bit              has_wb;
      mem_req_t        req;
      reg_form = op inside {op_add, op_sub, op_and, op_or, op_xor, op_slt};
      a        = pred_regs[rs1];
      if (reg_form) begin
         b    = pred_regs[src2];
         word = {op, rd[4:0], rs1[4:0], src2[4:0], 13'b0};
      end else begin
         b    = src2;
         word = {op, rd[4:0], rs1[4:0], src2[17:0]};
      end
      addr = a + b;
      res  = '0;
      case (op)
         op_add, op_addi: res = a + b;
         op_sub:          res = a - b;
         op_and, op_andi: res = a & b;
         op_or, op_ori:   res = a | b;
         op_xor:          res = a ^ b;
         op_slt:          res = ($signed(a) < $signed(b)) ? 1 : 0;
         op_load:         res = pred_mem[addr[7:2]];
         op_store:        pred_mem[addr[7:2]] = pred_regs[rd];
         default:         res = '0;
      endcase
      if (op inside {op_load, op_store}) begin
         req.we    = (op == op_store);
         req.addr  = addr;
         req.wdata = pred_regs[rd];
         exp_mem.push_back(req);
      end
      has_wb = (op != op_store) && (rd != 0);
      if (has_wb) begin
         pred_regs[rd] = res;
         wb_expected++;
      end
      row_word.push_back(word);
      row_rd.push_back(rd[4:0]);
      row_data.push_back(res);
      row_wb.push_back(has_wb);
      row_alu.push_back(!(op inside {op_load, op_store}));
   endtask

   task automatic fill_table();
      for (int i = 0; i < 32; i++) begin
         pred_regs[i] = '0;
      end
      for (int i = 0; i < 64; i++) begin
         pred_mem[i] = 32'ha5a5_0000 ^ (i * 32'h0001_0203);
      end
      // registers read zero after reset
      add_inst(op_add, 1, 0, 0);
      add_inst(op_add, 5, 7, 9);
      // every ALU opcode
      add_inst(op_addi, 2, 0, 1234);
      add_inst(op_addi, 3, 0, -77);
      add_inst(op_add, 4, 2, 3);
      add_inst(op_sub, 6, 2, 3);
      add_inst(op_and, 7, 3, 2);
      add_inst(op_or, 17, 7, 3);
      add_inst(op_xor, 10, 3, 2);
      add_inst(op_slt, 11, 3, 2);
      add_inst(op_slt, 12, 2, 3);
      add_inst(op_andi, 8, 3, 'h0ff0);
      add_inst(op_ori, 9, 2, -4096);
      // dependency chains through m and w
      add_inst(op_addi, 13, 13, 5);
      add_inst(op_addi, 13, 13, 7);
      add_inst(op_add, 14, 13, 13);
      add_inst(op_sub, 15, 14, 13);
      add_inst(op_add, 16, 15, 14);
      add_inst(op_xor, 18, 16, 13);
      // stores and loads
      add_inst(op_addi, 20, 0, 64);
      add_inst(op_store, 10, 20, 8);
      add_inst(op_load, 21, 20, 8);
      add_inst(op_add, 22, 21, 2);
      add_inst(op_store, 13, 20, -4);
      add_inst(op_store, 16, 0, 200);
      add_inst(op_load, 23, 20, -4);
      add_inst(op_load, 24, 0, 200);
      add_inst(op_load, 25, 0, 12);
      add_inst(op_sub, 26, 24, 23);
      // r0 stays zero
      add_inst(op_addi, 0, 0, 99);
      add_inst(op_add, 0, 2, 3);
      add_inst(op_load, 0, 20, 8);
      add_inst(op_add, 27, 0, 0);
      add_inst(op_addi, 28, 0, 3);
      add_inst(op_or, 29, 0, 9);
   endtask

   task automatic apply_rows();
      int waited;
      for (int i = 0; i < row_word.size(); i++) begin
         issue.valid = 1'b1;
         issue.word  = row_word[i];
         waited      = 0;
         @(negedge clk);
         while (stall) begin
            waited++;
            if (waited > 40) begin
               report_timeout("stall to drop");
            end
            @(negedge clk);
         end
         accept_cycle[i] = cycle;
         @(posedge clk);
         #2;
      end
      issue = '0;
   endtask

   task automatic collect_wb();
      int waited;
      for (int i = 0; i < row_word.size(); i++) begin
         if (row_wb[i]) begin
            waited = 0;
            @(negedge clk);
            while (!wb.valid) begin
               waited++;
               if (waited > 60) begin
                  report_timeout("a writeback event");
               end
               @(negedge clk);
            end
            check_val("wb.rd", wb.rd, row_rd[i]);
            check_val("wb.data", wb.data, row_data[i]);
            if (row_alu[i]) begin
               check_val("wb latency", cycle - accept_cycle[i], 3);
            end
         end
      end
   endtask

   initial begin
      repeat (5000) @(posedge clk);
      report_timeout("the run to finish");
   end

   initial begin
      rst_n = 1'b0;
      issue = '0;
      fill_table();
      repeat (10) @(posedge clk);
      #2;
      rst_n = 1'b1;
      @(negedge clk);
      check_val("stall after reset", stall, 0);
      check_val("mem_req after reset", mem_req, 0);
      check_val("wb.valid after reset", wb.valid, 0);
      @(posedge clk);
      #2;
      fork
         apply_rows();
         collect_wb();
      join
      repeat (5) @(posedge clk);
      check_val("wb event count", wb_count, wb_expected);
      check_val("pending memory requests", exp_mem.size(), 0);
      $display("** PASS **");
      $finish;
   end

endmodule

// File: files.f
source/exu_pkg.sv
source/exu_issue_ctrl.sv
source/exu_regfile.sv
source/exu_bypass.sv
source/exu_alu.sv
source/exu_writeback.sv
source/exu_top.sv
tests/tb_mem_model.sv
tests/tb_exu_top.sv

// File: Bender.yml
package:
  name: exu

sources:
  - source/exu_pkg.sv
  - source/exu_issue_ctrl.sv
  - source/exu_regfile.sv
  - source/exu_bypass.sv
  - source/exu_alu.sv
  - source/exu_writeback.sv
  - source/exu_top.sv
  - target: test
    files:
      - tests/tb_mem_model.sv
      - tests/tb_exu_top.sv
